// ==== vlog.f ====
source/isaPkg.sv
source/corePkg.sv
source/fetchDecode.sv
source/regFile.sv
source/aluExecute.sv
source/resultStage.sv
source/cpuCore.sv
dv/cpuCore_properties.sv
dv/cpuCore_tb.sv

// ==== Makefile ====
TOOL      := verilator
TOP       := cpuCore_tb
FILELIST  := vlog.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
BUILDDIR  := obj_dir
LOG       := sim.log
PASSMSG   := TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: build
	./$(BUILDDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASSMSG)$$" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== dv/cpuCore_tb.sv ====
// Random-program testbench for the CPU core, checked against an instruction-set model
`timescale 1ns/10ps
module cpuCore_tb;
    import isaPkg::*;
    import corePkg::*;

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 5;
    localparam int numProgs    = 4;
    localparam int progWords   = 256;
    localparam int maxRetires  = 400;   // Run is dropped after this many retires
    localparam int maxStalls   = 32;    // Random run-low cycles allowed per program
    localparam int slackCycles = 20;
    localparam int watchdogCycles =
        numProgs * (resetCycles + progWords + maxRetires + maxStalls + slackCycles) + resetCycles;

    logic     clk = 1'b0;
    logic     rst;
    logic     run;
    progLoadT progLoad;
    logic     halted;
    retireT   retire;

    integer      seed   = 32'hf97a3e05;
    int          errors = 0;
    int          checks = 0;
    logic [15:0] mProg [256];           // Model copy of program memory
    logic [15:0] mReg [8];
    logic [15:0] mMem [256];
    logic [15:0] mPc;
    logic        mHalted;
    logic        eRegWrite;             // Expected retire fields of the current word
    logic        eMemWr;
    logic        eHalt;
    logic        eIllegal;
    logic [2:0]  eWrReg;
    logic [15:0] eWrData;
    logic [15:0] eMemAddr;
    logic [15:0] eMemData;
    logic [15:0] eNextPc;

    always #(clkPeriod / 2) clk = ~clk;

    cpuCore cpuCore_i (
        .clk(clk), .rst(rst), .run(run), .progLoad(progLoad),
        .halted(halted), .retire(retire)
    );

    // Kinds 0 to 3 are add, sub (y minus x), xor, andn; 4 to 7 are rol, sll, ror, srl
    function automatic logic [15:0] aluCalc(input logic [2:0] kind, input logic [15:0] x,
                                            input logic [15:0] y);
        logic [3:0]  n;
        logic [15:0] res;
        n = y[3:0];
        case (kind)
            3'd0:    res = x + y;
            3'd1:    res = y - x;
            3'd2:    res = x ^ y;
            3'd3:    res = x & ~y;
            3'd4:    res = (x << n) | (x >> (5'd16 - n));  // Zero rotate leaves x
            3'd5:    res = x << n;
            3'd6:    res = (x >> n) | (x << (5'd16 - n));
            default: res = x >> n;
        endcase
        return res;
    endfunction

    function automatic logic [15:0] bitReverse(input logic [15:0] x);
        logic [15:0] res;
        for (int i = 0; i < 16; i++) begin
            res[i] = x[15 - i];
        end
        return res;
    endfunction

    // Expected effect of the word at the model PC
    task automatic predict();
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] s5;
        logic [15:0] s8;
        logic [15:0] s11;
        logic [15:0] addr;
        logic [16:0] carry;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [2:0]  rdR;
        logic [1:0]  funct;
        logic        bad;
        logic        taken;
        opcodeE      op;
        w     = mProg[mPc[8:1]];
        op    = opcodeE'(w[15:11]);
        rs    = w[10:8];
        rt    = w[7:5];                               // Rd of I-format 1
        rdR   = w[4:2];
        funct = w[1:0];
        a     = mReg[rs];
        b     = mReg[rt];
        s5    = {{11{w[4]}}, w[4:0]};
        s8    = {{8{w[7]}}, w[7:0]};
        s11   = {{5{w[10]}}, w[10:0]};
        carry = {1'b0, a} + {1'b0, b};
        bad   = 1'b0;
        {eRegWrite, eMemWr, eHalt, eWrReg} = '0;
        {eWrData, eMemAddr, eMemData} = '0;
        eNextPc = mPc + 16'd2;
        case (op)
            opHalt, opSiic: eHalt = 1'b1;
            opNop, opRti: begin
            end
            opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
                eRegWrite = 1'b1;
                eWrReg    = rt;
                eWrData   = aluCalc(w[13:11], a, w[12] ? {11'd0, w[4:0]} : s5);  // Zext on bit 1
            end
            opSt, opStu, opLd: begin
                addr     = a + s5;
                eMemAddr = addr;
                if (op == opLd) begin
                    eMemData  = mMem[addr[8:1]];
                    eRegWrite = 1'b1;
                    eWrReg    = rt;
                    eWrData   = eMemData;
                end else begin
                    eMemWr   = 1'b1;
                    eMemData = b;                     // Store data is Rd's value
                end
                if (op == opStu) begin
                    eRegWrite = 1'b1;
                    eWrReg    = rs;
                    eWrData   = addr;
                end
            end
            opLbi, opSlbi: begin
                eRegWrite = 1'b1;
                eWrReg    = rs;
                eWrData   = (op == opLbi) ? s8 : ({a[7:0], 8'h00} | {8'h00, w[7:0]});
            end
            opBtr, opAluR, opShiftR, opSeq, opSlt, opSle, opSco: begin
                bad       = (op != opAluR && op != opShiftR && funct != 2'b00);
                eRegWrite = 1'b1;
                eWrReg    = rdR;
                case (op)
                    opBtr:    eWrData = bitReverse(a);
                    opAluR:   eWrData = aluCalc({1'b0, funct}, a, b);
                    opShiftR: eWrData = aluCalc({1'b1, funct}, a, b);
                    opSeq:    eWrData = {15'd0, a == b};
                    opSlt:    eWrData = {15'd0, $signed(a) < $signed(b)};
                    opSle:    eWrData = {15'd0, $signed(a) <= $signed(b)};
                    default:  eWrData = {15'd0, carry[16]};
                endcase
            end
            opBeqz, opBnez, opBltz, opBgez: begin
                case (op)
                    opBeqz:  taken = (a == 16'd0);
                    opBnez:  taken = (a != 16'd0);
                    opBltz:  taken = a[15];
                    default: taken = !a[15];
                endcase
                if (taken) eNextPc = mPc + 16'd2 + s8;
            end
            opJ, opJal: eNextPc = mPc + 16'd2 + s11;
            default:    eNextPc = a + s8;             // JR and JALR
        endcase
        if (op == opJal || op == opJalr) begin
            eRegWrite = 1'b1;
            eWrReg    = 3'd7;
            eWrData   = mPc + 16'd2;                  // Link value
        end
        if (bad) begin
            eRegWrite = 1'b0;                         // Illegal encoding halts only
            eHalt     = 1'b1;
        end
        eIllegal = bad;
        if (eHalt) eNextPc = mPc;
    endtask

    task automatic reportMismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
        errors++;
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic checkRetire();
        predict();
        checks++;
        if (retire.pc !== mPc) reportMismatch("retire.pc", retire.pc, mPc);
        if (retire.instr !== mProg[mPc[8:1]])
            reportMismatch("retire.instr", retire.instr, mProg[mPc[8:1]]);
        if (retire.regWrite !== eRegWrite)
            reportMismatch("retire.regWrite", 16'(retire.regWrite), 16'(eRegWrite));
        if (eRegWrite && retire.wrReg !== eWrReg)
            reportMismatch("retire.wrReg", 16'(retire.wrReg), 16'(eWrReg));
        if (eRegWrite && retire.wrData !== eWrData)
            reportMismatch("retire.wrData", retire.wrData, eWrData);
        if (retire.memWr !== eMemWr)
            reportMismatch("retire.memWr", 16'(retire.memWr), 16'(eMemWr));
        if (retire.memAddr !== eMemAddr)
            reportMismatch("retire.memAddr", retire.memAddr, eMemAddr);
        if (retire.memData !== eMemData)
            reportMismatch("retire.memData", retire.memData, eMemData);
        if (retire.halt !== eHalt) reportMismatch("retire.halt", 16'(retire.halt), 16'(eHalt));
        if (retire.illegal !== eIllegal)
            reportMismatch("retire.illegal", 16'(retire.illegal), 16'(eIllegal));
        if (eRegWrite) mReg[eWrReg] = eWrData;       // Commit to the model
        if (eMemWr) mMem[eMemAddr[8:1]] = eMemData;
        mPc     = eNextPc;
        mHalted = eHalt;
    endtask

    task automatic applyReset();
        rst <= 1'b1;
        run <= 1'b0;
        repeat (resetCycles) @(posedge clk);
        rst     <= 1'b0;
        mPc     = 16'd0;
        mHalted = 1'b0;
        foreach (mReg[i]) mReg[i] = 16'd0;
        foreach (mMem[i]) mMem[i] = 16'd0;
        @(posedge clk);
        if (halted !== 1'b0 || retire.valid !== 1'b0) begin
            errors++;
            $display("After reset halted is %b and retire valid is %b", halted, retire.valid);
        end
    endtask

    // Random words with rare halts and rare nonzero function bits on checked R-formats
    task automatic loadProgram();
        logic [31:0] r;
        logic [31:0] q;
        logic [15:0] w;
        for (int i = 0; i < progWords; i++) begin
            r = $random(seed);
            q = $random(seed);
            w = r[15:0];
            if ((w[15:11] == opHalt || w[15:11] == opSiic) && q[4:0] != 5'd0) w[15:11] = opNop;
            if ((w[15:11] == opBtr || w[15:13] == 3'b111) && q[9:5] != 5'd0) w[1:0] = 2'b00;
            mProg[i] = w;
            @(posedge clk);
            progLoad <= '{wrEn: 1'b1, addr: i[7:0], data: w};
        end
        @(posedge clk);
        progLoad <= '0;
    endtask

    task automatic runProgram(input int prog);
        logic [31:0] r;
        int          count;
        int          stalls;
        count  = 0;
        stalls = 0;
        run <= 1'b1;
        while (!mHalted && count < maxRetires) begin
            @(posedge clk);
            if (retire.valid !== run) begin
                errors++;
                $display("Retire valid is %b at %0t while run is %b", retire.valid, $time, run);
            end
            if (retire.valid === 1'b1) begin
                checkRetire();
                count++;
            end
            r = $random(seed);
            if (stalls < maxStalls && r[3:0] == 4'd0) begin
                run <= 1'b0;                          // One stalled cycle
                stalls++;
            end else begin
                run <= 1'b1;
            end
        end
        if (mHalted) begin
            run <= 1'b1;
            repeat (3) begin
                @(posedge clk);
                if (halted !== 1'b1 || retire.valid !== 1'b0) begin
                    errors++;
                    $display("After a halt, halted is %b and retire valid is %b", halted,
                             retire.valid);
                end
            end
        end
        run <= 1'b0;
        $display("Program %0d ran %0d retires, halted %b", prog, count, mHalted);
    endtask

    initial begin
        rst      = 1'b1;
        run      = 1'b0;
        progLoad = '0;
        for (int p = 0; p < numProgs; p++) begin
            applyReset();
            loadProgram();
            runProgram(p);
        end
        applyReset();
        errors += cpuCore_i.cpuCore_properties_i.failCount;  // Bound assertion failures
        $display("Retires checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Watchdog expired after %0d cycles with %0d retires checked", watchdogCycles,
                 checks);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== dv/cpuCore_properties.sv ====
// Bound assertions on retire gating by run and halt, and on the sticky halted flag
`timescale 1ns/10ps
module cpuCore_properties (
    input logic            clk,
    input logic            rst,
    input logic            run,
    input logic            halted,
    input corePkg::retireT retire
);

    int failCount = 0;  // Assertion failures seen so far

    // A retire needs a stepping core
    validNeedsStep: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> (run && !halted))
        else begin
            failCount++;
            $error("retire valid while run is low or the core is halted");
        end

    // Only reset clears halted
    haltedSticky: assert property (@(posedge clk)
        (halted && !rst) |=> halted)
        else begin
            failCount++;
            $error("halted fell without reset");
        end

    haltRetireStops: assert property (@(posedge clk) disable iff (rst)
        (retire.valid && retire.halt) |=> halted)
        else begin
            failCount++;
            $error("halting retire not followed by halted");
        end

endmodule

bind cpuCore cpuCore_properties cpuCore_properties_i (
    .clk(clk), .rst(rst), .run(run), .halted(halted), .retire(retire)
);

// ==== source/cpuCore.sv ====
// CPU core top joining fetch/decode, register file, execute and result stages
`timescale 1ns/10ps
module cpuCore (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,        // Low stalls the core
    input  corePkg::progLoadT progLoad,
    output logic              halted,
    output corePkg::retireT   retire
);
    import isaPkg::*;
    import corePkg::*;

    logic [wordW-1:0]    pc;
    logic [wordW-1:0]    instr;
    logic [wordW-1:0]    imm;
    logic [wordW-1:0]    rsData;
    logic [wordW-1:0]    rtData;
    logic [wordW-1:0]    wrData;
    logic [regAddrW-1:0] rsIdx;
    logic [regAddrW-1:0] rtIdx;
    logic [regAddrW-1:0] destIdx;
    logic [regAddrW-1:0] wrIdx;
    logic                wrEn;
    ctrlT                ctrl;
    execT                exec;

    fetchDecode fetchDecode_i (
        .clk(clk), .rst(rst), .run(run), .progLoad(progLoad), .exec(exec),
        .pc(pc), .instr(instr), .ctrl(ctrl), .imm(imm),
        .rsIdx(rsIdx), .rtIdx(rtIdx), .destIdx(destIdx), .halted(halted)
    );

    regFile regFile_i (
        .clk(clk), .rst(rst), .rsIdx(rsIdx), .rtIdx(rtIdx),
        .rsData(rsData), .rtData(rtData),
        .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData)
    );

    aluExecute aluExecute_i (
        .pc(pc), .rsData(rsData), .rtData(rtData), .imm(imm),
        .ctrl(ctrl), .exec(exec)
    );

    resultStage resultStage_i (
        .clk(clk), .rst(rst), .run(run), .halted(halted),
        .pc(pc), .instr(instr), .rsData(rsData), .rtData(rtData),
        .ctrl(ctrl), .destIdx(destIdx), .exec(exec),
        .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData), .retire(retire)
    );

endmodule

// ==== source/resultStage.sv ====
// Result stage with data memory, writeback select and retire record
`timescale 1ns/10ps
module resultStage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        run,
    input  logic                        halted,
    input  logic [isaPkg::wordW-1:0]    pc,
    input  logic [isaPkg::wordW-1:0]    instr,
    input  logic [isaPkg::wordW-1:0]    rsData,
    input  logic [isaPkg::wordW-1:0]    rtData,
    input  corePkg::ctrlT               ctrl,
    input  logic [isaPkg::regAddrW-1:0] destIdx,
    input  corePkg::execT               exec,
    output logic                        wrEn,
    output logic [isaPkg::regAddrW-1:0] wrIdx,
    output logic [isaPkg::wordW-1:0]    wrData,
    output corePkg::retireT             retire
);
    import isaPkg::*;

    logic [wordW-1:0]    dataMem [2**memAddrW];
    logic [memAddrW-1:0] memIdx;
    logic [wordW-1:0]    memRd;
    logic                step;
    logic                memWrite;

    assign step     = run & ~halted;
    assign memIdx   = exec.aluOut[memAddrW:1];    // Word index from byte address
    assign memRd    = dataMem[memIdx];
    assign memWrite = step & ctrl.memEnable & ctrl.memWr;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**memAddrW; i++) begin
                dataMem[i] <= '0;
            end
        end else if (memWrite) begin
            dataMem[memIdx] <= rtData;            // Rt field carries Rd for stores
        end
    end

    assign wrEn  = step & ctrl.regWrite;
    assign wrIdx = destIdx;

    always_comb begin
        if (ctrl.wbFromMem) begin
            wrData = memRd;
        end else if (ctrl.link) begin
            wrData = pc + wordW'(2);              // Return address for JAL and JALR
        end else begin
            wrData = exec.aluOut;                 // Includes STU's new Rs
        end
    end

    always_comb begin
        retire          = '0;
        retire.valid    = step;
        retire.pc       = pc;
        retire.instr    = instr;
        retire.regWrite = wrEn;
        retire.wrReg    = wrIdx;
        retire.wrData   = wrData;
        retire.memWr    = memWrite;
        retire.halt     = exec.halt;
        retire.illegal  = ctrl.illegal;
        if (ctrl.memEnable) begin
            retire.memAddr = exec.aluOut;
            retire.memData = ctrl.memWr ? rtData : memRd;
        end
    end

endmodule

// ==== source/aluExecute.sv ====
// ALU execute with operand select, ALU, branch condition and next PC
`timescale 1ns/10ps
module aluExecute (
    input  logic [isaPkg::wordW-1:0] pc,
    input  logic [isaPkg::wordW-1:0] rsData,
    input  logic [isaPkg::wordW-1:0] rtData,
    input  logic [isaPkg::wordW-1:0] imm,
    input  corePkg::ctrlT            ctrl,
    output corePkg::execT            exec
);
    import isaPkg::*;

    logic [wordW-1:0]   opA;
    logic [wordW-1:0]   opB;
    logic [3:0]         shAmt;
    logic [2*wordW-1:0] rolW;      // Doubled word, rotate falls out of a shift
    logic [2*wordW-1:0] rorW;
    logic [wordW:0]     sum;       // Carry out on top for SCO
    logic [wordW-1:0]   aluOut;
    logic [wordW-1:0]   pcInc;
    logic [wordW-1:0]   nextPc;
    logic               condMet;
    logic               taken;

    assign opA   = rsData;
    assign opB   = ctrl.aluSrcImm ? imm : rtData;
    assign shAmt = opB[3:0];
    assign rolW  = {opA, opA} << shAmt;
    assign rorW  = {opA, opA} >> shAmt;
    assign sum   = {1'b0, opA} + {1'b0, opB};
    assign pcInc = pc + wordW'(2);

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluOut = sum[wordW-1:0];
            aluSub:  aluOut = opB - opA;             // SUB and SUBI take B minus A
            aluXor:  aluOut = opA ^ opB;
            aluAndn: aluOut = opA & ~opB;
            aluRol:  aluOut = rolW[2*wordW-1 -: wordW];
            aluSll:  aluOut = opA << shAmt;
            aluRor:  aluOut = rorW[wordW-1:0];
            aluSrl:  aluOut = opA >> shAmt;
            aluBtr:  aluOut = {<<{opA}};             // Bit reverse
            aluSeq:  aluOut = wordW'(opA == opB);
            aluSlt:  aluOut = wordW'($signed(opA) < $signed(opB));
            aluSle:  aluOut = wordW'($signed(opA) <= $signed(opB));
            aluSco:  aluOut = wordW'(sum[wordW]);
            aluSlbi: aluOut = {opA[7:0], 8'h00} | opB;
            default: aluOut = opB;                   // LBI passes the immediate
        endcase
    end

    always_comb begin
        case (ctrl.branchCond)
            2'b00:   condMet = (rsData == '0);       // BEQZ
            2'b01:   condMet = (rsData != '0);       // BNEZ
            2'b10:   condMet = rsData[wordW-1];      // BLTZ
            default: condMet = ~rsData[wordW-1];     // BGEZ
        endcase
    end

    assign taken = ctrl.jump | (ctrl.branch & condMet);

    always_comb begin
        if (ctrl.halt) begin
            nextPc = pc;                             // Halting word holds the PC
        end else if (ctrl.regJump) begin
            nextPc = rsData + imm;                   // JR and JALR
        end else if (taken) begin
            nextPc = pcInc + imm;
        end else begin
            nextPc = pcInc;
        end
    end

    assign exec = '{aluOut: aluOut, nextPc: nextPc, taken: taken, halt: ctrl.halt};

endmodule

// ==== source/regFile.sv ====
// Register file of eight 16-bit registers, two combinational reads, one write
`timescale 1ns/10ps
module regFile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [isaPkg::regAddrW-1:0] rsIdx,
    input  logic [isaPkg::regAddrW-1:0] rtIdx,
    output logic [isaPkg::wordW-1:0]    rsData,
    output logic [isaPkg::wordW-1:0]    rtData,
    input  logic                        wrEn,
    input  logic [isaPkg::regAddrW-1:0] wrIdx,
    input  logic [isaPkg::wordW-1:0]    wrData
);
    import isaPkg::*;

    logic [wordW-1:0] regs [2**regAddrW];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;                 // Architectural state starts at zero
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    // Reads see the old value, the write lands on the retiring edge
    assign rsData = regs[rsIdx];
    assign rtData = regs[rtIdx];

endmodule

// ==== source/fetchDecode.sv ====
// Fetch and decode with program memory, PC, halted flag and control decoder
`timescale 1ns/10ps
module fetchDecode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        run,       // Core may step this cycle
    input  corePkg::progLoadT           progLoad,  // Program write port
    input  corePkg::execT               exec,      // Next PC and halt from execute
    output logic [isaPkg::wordW-1:0]    pc,
    output logic [isaPkg::wordW-1:0]    instr,
    output corePkg::ctrlT               ctrl,
    output logic [isaPkg::wordW-1:0]    imm,
    output logic [isaPkg::regAddrW-1:0] rsIdx,
    output logic [isaPkg::regAddrW-1:0] rtIdx,
    output logic [isaPkg::regAddrW-1:0] destIdx,
    output logic                        halted
);
    import isaPkg::*;

    logic [wordW-1:0] progMem [2**memAddrW];  // Contents survive core reset
    logic             step;
    opcodeE           op;
    logic [1:0]       funct;                  // R-format function bits
    immSelE           immSel;

    // ALU or shift group member picked by a two-bit selector
    function automatic aluOpE aluGroup(input logic shift, input logic [1:0] sel);
        aluOpE res;
        case ({shift, sel})
            3'b000:  res = aluAdd;
            3'b001:  res = aluSub;
            3'b010:  res = aluXor;
            3'b011:  res = aluAndn;
            3'b100:  res = aluRol;
            3'b101:  res = aluSll;
            3'b110:  res = aluRor;
            default: res = aluSrl;
        endcase
        return res;
    endfunction

    assign step  = run & ~halted;
    assign instr = progMem[pc[memAddrW:1]];        // Word index from byte PC
    assign op    = opcodeE'(instr[wordW-1 -: opW]);
    assign funct = instr[1:0];
    assign rsIdx = instr[rsLsb +: regAddrW];
    assign rtIdx = instr[rtLsb +: regAddrW];       // Same field holds Rd of stores

    always_ff @(posedge clk) begin
        if (progLoad.wrEn) begin
            progMem[progLoad.addr] <= progLoad.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (step) begin
            pc     <= exec.nextPc;
            halted <= exec.halt;                   // Sticky, step is low once set
        end
    end

    always_comb begin
        ctrl         = '0;
        ctrl.destSel = destRdI;
        ctrl.aluOp   = aluAdd;                     // Address arithmetic by default
        immSel       = immSext5;
        casez (op)
            5'b000??: ctrl.halt = ~op[0];          // HALT and SIIC stop, NOP and RTI idle
            5'b010??, 5'b101??: begin              // I-format 1 arithmetic and shifts
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluGroup(op[2], op[1:0]);
                immSel         = op[1] ? immZext5 : immSext5;
            end
            5'b1000?: begin                        // ST when bit 0 clear, LD when set
                ctrl.memEnable = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWr     = ~op[0];
                ctrl.regWrite  = op[0];
                ctrl.wbFromMem = op[0];
            end
            opStu: begin                           // Store, then Rs takes the address
                ctrl.memEnable = 1'b1;
                ctrl.memWr     = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.destSel   = destRs;
            end
            opLbi, opSlbi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.destSel   = destRs;
                ctrl.aluOp     = (op == opLbi) ? aluPassB : aluSlbi;
                immSel         = (op == opLbi) ? immSext8 : immZext8;
            end
            opBtr: begin
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = destRdR;
                ctrl.aluOp    = aluBtr;
                ctrl.illegal  = |funct;            // Function bits must be zero
            end
            opAluR, opShiftR: begin
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = destRdR;
                ctrl.aluOp    = aluGroup(~op[0], funct);
            end
            5'b111??: begin                        // SEQ, SLT, SLE, SCO
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = destRdR;
                ctrl.illegal  = |funct;
                case (op[1:0])
                    2'b00:   ctrl.aluOp = aluSeq;
                    2'b01:   ctrl.aluOp = aluSlt;
                    2'b10:   ctrl.aluOp = aluSle;
                    default: ctrl.aluOp = aluSco;
                endcase
            end
            5'b011??: begin                        // Conditional branches on Rs
                ctrl.branch     = 1'b1;
                ctrl.branchCond = op[1:0];
                immSel          = immSext8;
            end
            5'b001??: begin                        // J, JR, JAL, JALR
                ctrl.jump     = 1'b1;
                ctrl.regJump  = op[0];
                ctrl.link     = op[1];
                ctrl.regWrite = op[1];
                ctrl.destSel  = destR7;
                immSel        = op[0] ? immSext8 : immSext11;
            end
            default: ctrl.illegal = 1'b1;
        endcase
        if (ctrl.illegal) begin
            ctrl.regWrite = 1'b0;                  // Illegal words only halt
            ctrl.halt     = 1'b1;
        end
    end

    always_comb begin
        case (immSel)
            immSext5: imm = wordW'($signed(instr[4:0]));
            immZext5: imm = wordW'(instr[4:0]);
            immSext8: imm = wordW'($signed(instr[7:0]));
            immZext8: imm = wordW'(instr[7:0]);
            default:  imm = wordW'($signed(instr[10:0]));  // Jump displacement
        endcase
    end

    always_comb begin
        case (ctrl.destSel)
            destRs:  destIdx = rsIdx;
            destRdR: destIdx = instr[rdRLsb +: regAddrW];
            destRdI: destIdx = rtIdx;
            default: destIdx = regAddrW'(7);       // Link register
        endcase
    end

endmodule

// ==== source/corePkg.sv ====
// Core package with the control, program-load, execute and retire bundles
package corePkg;

    typedef struct packed {
        logic                        regWrite;    // Register writeback
        isaPkg::destSelE             destSel;     // Which field names the destination
        isaPkg::aluOpE               aluOp;
        logic                        aluSrcImm;   // B from immediate instead of Rt
        logic                        memEnable;   // Data memory access
        logic                        memWr;
        logic                        wbFromMem;   // LD result
        logic                        branch;
        logic [1:0]                  branchCond;  // Zero, nonzero, negative, non-negative
        logic                        jump;
        logic                        regJump;     // Target from Rs
        logic                        link;        // R7 gets PC plus 2
        logic                        halt;
        logic                        illegal;
    } ctrlT;

    typedef struct packed {
        logic                        wrEn;
        logic [isaPkg::memAddrW-1:0] addr;        // Word index
        logic [isaPkg::wordW-1:0]    data;
    } progLoadT;

    typedef struct packed {
        logic [isaPkg::wordW-1:0]    aluOut;
        logic [isaPkg::wordW-1:0]    nextPc;
        logic                        taken;       // Branch taken or jump
        logic                        halt;
    } execT;

    typedef struct packed {
        logic                        valid;
        logic [isaPkg::wordW-1:0]    pc;
        logic [isaPkg::wordW-1:0]    instr;
        logic                        regWrite;
        logic [isaPkg::regAddrW-1:0] wrReg;
        logic [isaPkg::wordW-1:0]    wrData;
        logic                        memWr;
        logic [isaPkg::wordW-1:0]    memAddr;     // Byte address, 0 without access
        logic [isaPkg::wordW-1:0]    memData;     // Stored or loaded word
        logic                        halt;
        logic                        illegal;
    } retireT;

endpackage

// ==== source/isaPkg.sv ====
// ISA package with opcode and ALU enums, instruction field positions and widths
package isaPkg;

    localparam int wordW    = 16;  // Data and instruction width
    localparam int regAddrW = 3;   // Eight architectural registers
    localparam int memAddrW = 8;   // Both memories hold 256 words
    localparam int opW      = 5;   // Major opcode in bits 15 to 11
    localparam int rsLsb    = 8;   // Rs in bits 10 to 8
    localparam int rtLsb    = 5;   // Rt of R-format, Rd of I-format 1
    localparam int rdRLsb   = 2;   // Rd of R-format in bits 4 to 2

    // Grouped by format, as in the decoder
    typedef enum logic [opW-1:0] {
        opHalt  = 5'b00000, opNop   = 5'b00001, opSiic  = 5'b00010, opRti   = 5'b00011,
        opJ     = 5'b00100, opJr    = 5'b00101, opJal   = 5'b00110, opJalr  = 5'b00111,
        opAddi  = 5'b01000, opSubi  = 5'b01001, opXori  = 5'b01010, opAndni = 5'b01011,
        opBeqz  = 5'b01100, opBnez  = 5'b01101, opBltz  = 5'b01110, opBgez  = 5'b01111,
        opSt    = 5'b10000, opLd    = 5'b10001, opSlbi  = 5'b10010, opStu   = 5'b10011,
        opRoli  = 5'b10100, opSlli  = 5'b10101, opRori  = 5'b10110, opSrli  = 5'b10111,
        opLbi   = 5'b11000, opBtr   = 5'b11001, opShiftR = 5'b11010, opAluR = 5'b11011,
        opSeq   = 5'b11100, opSlt   = 5'b11101, opSle   = 5'b11110, opSco   = 5'b11111
    } opcodeE;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluXor, aluAndn,  // Sub is operand B minus A
        aluRol, aluSll, aluRor, aluSrl,   // Shift amount from B[3:0]
        aluBtr, aluSeq, aluSlt, aluSle, aluSco,
        aluPassB,                         // LBI
        aluSlbi
    } aluOpE;

    typedef enum logic [2:0] {
        immSext5, immZext5, immSext8, immZext8, immSext11
    } immSelE;

    typedef enum logic [1:0] {
        destRs, destRdR, destRdI, destR7
    } destSelE;

endpackage
